/* dma_pkg.sv */
package dma_pkg;

  ////////////////////////////////////////////////////////////////////
  // ADMA2 engine states and descriptor encoding
  ////////////////////////////////////////////////////////////////////

  // stop, fetch a descriptor line, change address on link, move data
  typedef enum logic [1:0] {
    st_stop             = 2'b00,
    st_fetch_descriptor = 2'b01,
    st_change_address   = 2'b10,
    st_transfer         = 2'b11
  } adma_state_e;

  // act field of a descriptor line
  typedef enum logic [1:0] {
    act_nop      = 2'b00,
    act_reserved = 2'b01,
    act_tran     = 2'b10,
    act_link     = 2'b11
  } act_e;

  // one 64-bit descriptor line, as it sits in system memory
  typedef struct packed {
    logic [31:0] address;
    // bytes, 0 means 65536
    logic [15:0] length;
    logic [9:0]  reserved_hi;
    act_e        act;
    logic [1:0]  reserved_lo;
    logic        end_flag;
    logic        valid;
  } descriptor_t;

  // start inputs from the register block
  typedef struct packed {
    logic        enable;
    logic        card_to_mem;
    logic        cmd_done;
    logic        data_present;
    logic        blk_gap_req;
    logic [31:0] descriptor_ptr;
  } dma_cmd_t;

  ////////////////////////////////////////////////////////////////////
  // engine to mover
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    op_idle             = 2'b00,
    op_fetch_descriptor = 2'b01,
    op_mem_to_card      = 2'b10,
    op_card_to_mem      = 2'b11
  } mover_op_e;

  // one-cycle request, words counts 32-bit words
  typedef struct packed {
    mover_op_e   op;
    logic [31:0] address;
    logic [16:0] words;
    logic        hold_address;
    logic        pad;
  } mover_req_t;

  // read beat forwarded into the card data FIFO
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } fifo_wr_t;

  // byte step between descriptor lines, words per line
  localparam int DESCRIPTOR_STEP  = 8;
  localparam int DESCRIPTOR_WORDS = 2;

endpackage

/* axi_pkg.sv */
package axi_pkg;

  ////////////////////////////////////////////////////////////////////
  // AXI channel bundles, only the fields the DMA master uses
  ////////////////////////////////////////////////////////////////////

  // write address
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [7:0]  len;
  } aw_t;

  // read address
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [7:0]  len;
  } ar_t;

  // write data
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } w_t;

  // read data
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } r_t;

  // all beats are one 32-bit word
  localparam logic [2:0] SIZE_WORD = 3'b010;

  // incrementing bursts only
  localparam logic [1:0] BURST_INCR = 2'b01;

endpackage

/* adma_descriptor_engine.sv */
`timescale 1ns/1ps

module adma_descriptor_engine (
  input  logic                 clock,
  input  logic                 reset,
  input  dma_pkg::dma_cmd_t    cmd,
  input  logic                 xfer_compl,
  input  logic                 int_clear,
  input  logic                 busy,
  input  dma_pkg::descriptor_t descriptor,
  output dma_pkg::mover_req_t  req,
  output logic [1:0]           dma_interrupts
);

  dma_pkg::adma_state_e state;
  logic [31:0]          descriptor_ptr;
  logic                 mover_done;
  logic                 last_descriptor;
  logic [16:0]          tran_words;

  // request strobe gone and mover back to idle
  assign mover_done = (req.op == dma_pkg::op_idle) && !busy;

  // end of chain, or a block gap stop after this line
  assign last_descriptor = descriptor.end_flag || cmd.blk_gap_req;

  // bytes to words, a zero length is the full 64 KiB
  assign tran_words = (descriptor.length == 16'd0) ? 17'd16384 :
                      {3'b000, descriptor.length[15:2]};

  // fetch request for one descriptor line
  function automatic dma_pkg::mover_req_t fetch_req(input logic [31:0] address);
    dma_pkg::mover_req_t r;
    r.op           = dma_pkg::op_fetch_descriptor;
    r.address      = address;
    r.words        = 17'(dma_pkg::DESCRIPTOR_WORDS);
    r.hold_address = 1'b1;
    r.pad          = 1'b0;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // ADMA2 FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state          <= dma_pkg::st_stop;
      descriptor_ptr <= '0;
      req            <= '0;
      dma_interrupts <= '0;
    end else begin
      // request lasts one cycle only
      req.op <= dma_pkg::op_idle;
      case (state)
        dma_pkg::st_stop: begin
          // start from the register block
          if (cmd.cmd_done && cmd.enable && cmd.data_present) begin
            descriptor_ptr <= cmd.descriptor_ptr;
            req            <= fetch_req(cmd.descriptor_ptr);
            state          <= dma_pkg::st_fetch_descriptor;
          end
        end
        dma_pkg::st_fetch_descriptor: begin
          if (mover_done) begin
            if (!descriptor.valid) begin
              // bad line, flag error and stop
              dma_interrupts[1] <= 1'b1;
              state             <= dma_pkg::st_stop;
            end else begin
              // next line by default, a link overrides it
              descriptor_ptr <= descriptor_ptr + 32'(dma_pkg::DESCRIPTOR_STEP);
              state          <= dma_pkg::st_change_address;
            end
          end
        end
        dma_pkg::st_change_address: begin
          if (descriptor.act == dma_pkg::act_link) begin
            // jump to another descriptor table
            descriptor_ptr <= descriptor.address;
            req            <= fetch_req(descriptor.address);
            state          <= dma_pkg::st_fetch_descriptor;
          end else if (descriptor.act == dma_pkg::act_tran) begin
            req.op           <= cmd.card_to_mem ? dma_pkg::op_card_to_mem :
                                                  dma_pkg::op_mem_to_card;
            req.address      <= descriptor.address;
            req.words        <= tran_words;
            req.hold_address <= 1'b0;
            req.pad          <= 1'b0;
            state            <= dma_pkg::st_transfer;
          end else begin
            // nop and reserved move no data
            state <= dma_pkg::st_transfer;
          end
        end
        dma_pkg::st_transfer: begin
          if (mover_done) begin
            if (!last_descriptor) begin
              req   <= fetch_req(descriptor_ptr);
              state <= dma_pkg::st_fetch_descriptor;
            end else if (xfer_compl) begin
              // chain done once the serializer is done too
              dma_interrupts[0] <= 1'b1;
              state             <= dma_pkg::st_stop;
            end
          end
        end
        default: state <= dma_pkg::st_stop;
      endcase
      // clear pulse wins over a new interrupt
      if (int_clear) begin
        dma_interrupts <= '0;
      end
    end
  end

endmodule

/* burst_mover.sv */
`timescale 1ns/1ps

module burst_mover #(
  parameter int BURST_BEATS = 16
) (
  input  logic                 clock,
  input  logic                 reset,
  input  dma_pkg::mover_req_t  req,
  output logic                 busy,
  output dma_pkg::descriptor_t descriptor,
  input  logic [16:0]          fill_words,
  output logic                 clear_fill,
  output axi_pkg::aw_t         aw,
  output axi_pkg::w_t          w,
  output axi_pkg::ar_t         ar,
  input  logic                 aw_ready,
  input  logic                 w_ready,
  input  logic                 ar_ready,
  input  axi_pkg::r_t          r,
  output logic                 r_ready,
  input  logic [31:0]          fifo_rdata,
  output dma_pkg::fifo_wr_t    fifo_wr,
  output logic                 fifo_rd_pop,
  output logic                 fifo_reset,
  output logic                 start_write
);

  typedef enum logic [2:0] {
    mv_idle,
    mv_read_addr,
    mv_read_data,
    mv_write_wait,
    mv_write_addr,
    mv_write_data
  } mover_state_e;

  localparam int          BEAT_W      = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
  localparam logic [31:0] BURST_BYTES = 32'(4 * BURST_BEATS);
  localparam logic [7:0]  BURST_LEN   = 8'(BURST_BEATS - 1);

  mover_state_e       state;
  dma_pkg::mover_op_e op;
  logic [31:0]        address;
  logic [16:0]        words_total;
  logic [16:0]        words_done;
  logic [16:0]        words_next;
  logic               hold_address;
  logic [BEAT_W-1:0]  beat;
  logic               ar_valid;
  logic               aw_valid;
  logic               w_valid;
  logic               r_beat;
  logic               w_beat;
  logic               fifo_wr_valid;
  logic [31:0]        fifo_wr_data;

  assign busy       = (state != mv_idle);
  // fill count restarts for every request
  assign clear_fill = (state == mv_idle);
  assign words_next = words_done + 17'd1;

  ////////////////////////////////////////////////////////////////////
  // AXI channel outputs
  ////////////////////////////////////////////////////////////////////

  // address only moves after acceptance, so payload is stable
  assign ar.valid = ar_valid;
  assign ar.addr  = address;
  // descriptor fetch is a two beat burst
  assign ar.len   = (op == dma_pkg::op_fetch_descriptor) ? 8'd1 : BURST_LEN;

  assign aw.valid = aw_valid;
  assign aw.addr  = address;
  assign aw.len   = BURST_LEN;

  // FIFO head word goes out directly, popped on acceptance
  assign w.valid  = w_valid;
  assign w.data   = fifo_rdata;
  assign w.last   = (beat == BEAT_W'(BURST_BEATS - 1));

  assign r_ready  = (state == mv_read_data);
  assign r_beat   = r.valid && r_ready;
  assign w_beat   = w_valid && w_ready;

  assign fifo_rd_pop   = w_beat;
  assign fifo_wr.valid = fifo_wr_valid;
  assign fifo_wr.data  = fifo_wr_data;

  ////////////////////////////////////////////////////////////////////
  // burst FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state         <= mv_idle;
      op            <= dma_pkg::op_idle;
      address       <= '0;
      words_total   <= '0;
      words_done    <= '0;
      hold_address  <= 1'b0;
      beat          <= '0;
      ar_valid      <= 1'b0;
      aw_valid      <= 1'b0;
      w_valid       <= 1'b0;
      fifo_wr_valid <= 1'b0;
      fifo_reset    <= 1'b0;
      start_write   <= 1'b0;
    end else begin
      fifo_reset    <= 1'b0;
      fifo_wr_valid <= 1'b0;
      case (state)
        mv_idle: begin
          if (req.op != dma_pkg::op_idle) begin
            op           <= req.op;
            address      <= req.address;
            words_total  <= req.words;
            hold_address <= req.hold_address;
            words_done   <= '0;
            // fresh FIFO for each data transfer
            fifo_reset   <= (req.op != dma_pkg::op_fetch_descriptor);
            if (req.op == dma_pkg::op_card_to_mem) begin
              state <= mv_write_wait;
            end else begin
              ar_valid <= 1'b1;
              state    <= mv_read_addr;
            end
          end
        end
        mv_read_addr: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            if (!hold_address) begin
              address <= address + BURST_BYTES;
            end
            // tell the serializer memory data is on its way
            if (op == dma_pkg::op_mem_to_card) begin
              start_write <= 1'b1;
            end
            state <= mv_read_data;
          end
        end
        mv_read_data: begin
          if (r_beat) begin
            words_done    <= words_next;
            fifo_wr_valid <= (op == dma_pkg::op_mem_to_card);
            if (r.last) begin
              if (words_next == words_total) begin
                start_write <= 1'b0;
                state       <= mv_idle;
              end else begin
                ar_valid <= 1'b1;
                state    <= mv_read_addr;
              end
            end
          end
        end
        mv_write_wait: begin
          // a full burst must already sit in the FIFO
          if (fill_words >= words_done + 17'(BURST_BEATS)) begin
            aw_valid <= 1'b1;
            state    <= mv_write_addr;
          end
        end
        mv_write_addr: begin
          if (aw_ready) begin
            aw_valid <= 1'b0;
            address  <= address + BURST_BYTES;
            beat     <= '0;
            w_valid  <= 1'b1;
            state    <= mv_write_data;
          end
        end
        mv_write_data: begin
          if (w_beat) begin
            words_done <= words_next;
            beat       <= beat + 1'b1;
            if (w.last) begin
              w_valid <= 1'b0;
              state   <= (words_next == words_total) ? mv_idle : mv_write_wait;
            end
          end
        end
        default: state <= mv_idle;
      endcase
    end
  end

  // read payload, descriptor low word arrives first
  always_ff @(posedge clock) begin
    if (r_beat) begin
      fifo_wr_data <= r.data;
      if (op == dma_pkg::op_fetch_descriptor) begin
        descriptor <= {r.data, descriptor[63:32]};
      end
    end
  end

endmodule

/* fifo_fill_tracker.sv */
`timescale 1ns/1ps

module fifo_fill_tracker #(
  parameter int BURST_BEATS = 16
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        fifo_we,
  input  logic        clear_fill,
  output logic [16:0] fill_words
);

  logic we_meta;
  logic we_sync;
  logic we_fall;

  // 16384 words of a 64 KiB line plus one burst of slack fit in 17 bits
  if (16384 + BURST_BEATS >= (1 << 17)) begin : g_width_check
    $error("fill counter too narrow for BURST_BEATS");
  end

  // one word written per falling edge of the FIFO write enable
  assign we_fall = we_sync && !we_meta;

  always_ff @(posedge clock) begin
    if (!reset) begin
      we_meta    <= 1'b0;
      we_sync    <= 1'b0;
      fill_words <= '0;
    end else begin
      // two flop sync from the card clock side
      we_meta <= fifo_we;
      we_sync <= we_meta;
      if (clear_fill) begin
        fill_words <= '0;
      end else if (we_fall) begin
        fill_words <= fill_words + 17'd1;
      end
    end
  end

endmodule

/* sd_dma_top.sv */
`timescale 1ns/1ps

module sd_dma_top #(
  parameter int BURST_BEATS = 16
) (
  input  logic              clock,
  input  logic              reset,
  // register block and serializer
  input  dma_pkg::dma_cmd_t cmd,
  input  logic              xfer_compl,
  input  logic              int_clear,
  output logic [1:0]        dma_interrupts,
  output logic              start_write,
  // card data FIFO
  input  logic              fifo_we,
  input  logic [31:0]       fifo_rdata,
  output dma_pkg::fifo_wr_t fifo_wr,
  output logic              fifo_rd_pop,
  output logic              fifo_reset,
  // AXI master
  output axi_pkg::aw_t      aw,
  input  logic              aw_ready,
  output logic [2:0]        aw_size,
  output logic [1:0]        aw_burst,
  output axi_pkg::w_t       w,
  input  logic              w_ready,
  output axi_pkg::ar_t      ar,
  input  logic              ar_ready,
  output logic [2:0]        ar_size,
  output logic [1:0]        ar_burst,
  input  axi_pkg::r_t       r,
  output logic              r_ready
);

  dma_pkg::mover_req_t  req;
  dma_pkg::descriptor_t descriptor;
  logic                 busy;
  logic [16:0]          fill_words;
  logic                 clear_fill;

  // word beats, INCR bursts on both channels
  assign aw_size  = axi_pkg::SIZE_WORD;
  assign ar_size  = axi_pkg::SIZE_WORD;
  assign aw_burst = axi_pkg::BURST_INCR;
  assign ar_burst = axi_pkg::BURST_INCR;

  ////////////////////////////////////////////////////////////////////
  // descriptor FSM, burst mover, FIFO fill pacing
  ////////////////////////////////////////////////////////////////////

  adma_descriptor_engine u_engine (
    .clock          (clock),
    .reset          (reset),
    .cmd            (cmd),
    .xfer_compl     (xfer_compl),
    .int_clear      (int_clear),
    .busy           (busy),
    .descriptor     (descriptor),
    .req            (req),
    .dma_interrupts (dma_interrupts)
  );

  burst_mover #(
    .BURST_BEATS (BURST_BEATS)
  ) u_mover (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .busy        (busy),
    .descriptor  (descriptor),
    .fill_words  (fill_words),
    .clear_fill  (clear_fill),
    .aw          (aw),
    .w           (w),
    .ar          (ar),
    .aw_ready    (aw_ready),
    .w_ready     (w_ready),
    .ar_ready    (ar_ready),
    .r           (r),
    .r_ready     (r_ready),
    .fifo_rdata  (fifo_rdata),
    .fifo_wr     (fifo_wr),
    .fifo_rd_pop (fifo_rd_pop),
    .fifo_reset  (fifo_reset),
    .start_write (start_write)
  );

  fifo_fill_tracker #(
    .BURST_BEATS (BURST_BEATS)
  ) u_tracker (
    .clock      (clock),
    .reset      (reset),
    .fifo_we    (fifo_we),
    .clear_fill (clear_fill),
    .fill_words (fill_words)
  );

endmodule

/* tb_sd_dma.sv */
`timescale 1ns/1ps

module tb_sd_dma;

  // small bursts keep the data areas short
  localparam int          BURST_BEATS = 4;
  localparam logic [31:0] C2M_BASE    = 32'hc0de_0000;
  localparam int          MAX_TESTS   = 8;
  // AXI encodings for 4-byte beats and incrementing bursts
  localparam logic [2:0]  WORD_SIZE   = 3'b010;
  localparam logic [1:0]  INCR_BURST  = 2'b01;

  logic                 clock;
  logic                 reset;
  dma_pkg::dma_cmd_t    cmd;
  logic                 xfer_compl;
  logic                 int_clear;
  logic                 fifo_we;
  logic [31:0]          fifo_rdata;
  logic                 aw_ready;
  logic                 w_ready;
  logic                 ar_ready;
  logic                 r_ready;
  axi_pkg::r_t          r;
  axi_pkg::aw_t         aw;
  axi_pkg::w_t          w;
  axi_pkg::ar_t         ar;
  logic [2:0]           aw_size;
  logic [2:0]           ar_size;
  logic [1:0]           aw_burst;
  logic [1:0]           ar_burst;
  dma_pkg::fifo_wr_t    fifo_wr;
  logic                 fifo_rd_pop;
  logic                 fifo_reset;
  logic                 start_write;
  logic [1:0]           dma_interrupts;

  // stimulus image and the tests decoded from it
  logic [31:0] stim [0:255];
  int          num_tests;
  int          total_words;
  logic        loaded;
  logic [31:0] t_ptr [MAX_TESTS];
  logic        t_dir [MAX_TESTS];
  logic        t_gap [MAX_TESTS];
  logic [1:0]  t_irq [MAX_TESTS];
  int          t_nf [MAX_TESTS];
  logic [31:0] t_fetch [MAX_TESTS][4];
  int          t_na [MAX_TESTS];
  logic [31:0] t_area_addr [MAX_TESTS][4];
  int          t_area_words [MAX_TESTS][4];

  // memory model state
  logic [31:0] mem [logic [31:0]];
  logic [31:0] rq_addr [$];
  logic [7:0]  rq_len [$];
  logic [31:0] fetch_q [$];
  logic [31:0] card_q [$];
  logic [31:0] rd_addr;
  int          rd_left;
  logic        rd_fetch;
  logic [31:0] wr_addr;
  int          wr_beat;
  int          fifo_idx;
  logic        b_ar;
  logic        b_aw;
  logic        b_w;
  logic        b_r;

  // per test bookkeeping
  int          data_words;
  int          test_words;
  int          written_words;
  int          we_count;
  int          reset_count;
  int          errors;
  logic [15:0] lfsr;

  sd_dma_top #(
    .BURST_BEATS (BURST_BEATS)
  ) DUT (
    .clock          (clock),
    .reset          (reset),
    .cmd            (cmd),
    .xfer_compl     (xfer_compl),
    .int_clear      (int_clear),
    .dma_interrupts (dma_interrupts),
    .start_write    (start_write),
    .fifo_we        (fifo_we),
    .fifo_rdata     (fifo_rdata),
    .fifo_wr        (fifo_wr),
    .fifo_rd_pop    (fifo_rd_pop),
    .fifo_reset     (fifo_reset),
    .aw             (aw),
    .aw_ready       (aw_ready),
    .aw_size        (aw_size),
    .aw_burst       (aw_burst),
    .w              (w),
    .w_ready        (w_ready),
    .ar             (ar),
    .ar_ready       (ar_ready),
    .ar_size        (ar_size),
    .ar_burst       (ar_burst),
    .r              (r),
    .r_ready        (r_ready)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // 16-bit galois lfsr stepped once per random bit
  function automatic logic random_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  // unlisted memory words get a pattern of the whole address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ 32'h5a5a_0000 ^ {a[7:0], 24'h0};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // flat hex tokens as laid out in the stim file header
  task automatic load_stim();
    int fd;
    int p;
    int n;
    loaded      = 1'b0;
    total_words = 0;
    fd = $fopen("sd_dma_stim.txt", "r");
    if (fd != 0) begin
      $fclose(fd);
      $readmemh("sd_dma_stim.txt", stim);
      n = int'(stim[0]);
      p = 1;
      for (int i = 0; i < n; i++) begin
        mem[stim[p]] = stim[p + 1];
        p += 2;
      end
      num_tests = int'(stim[p]);
      p++;
      if (num_tests > 0 && num_tests <= MAX_TESTS) begin
        for (int t = 0; t < num_tests; t++) begin
          t_ptr[t] = stim[p];
          t_dir[t] = stim[p + 1][0];
          t_gap[t] = stim[p + 2][0];
          t_irq[t] = stim[p + 3][1:0];
          t_nf[t]  = int'(stim[p + 4]);
          p += 5;
          for (int f = 0; f < t_nf[t]; f++) begin
            t_fetch[t][f] = stim[p];
            p++;
          end
          t_na[t] = int'(stim[p]);
          p++;
          for (int a = 0; a < t_na[t]; a++) begin
            t_area_addr[t][a]  = stim[p];
            t_area_words[t][a] = int'(stim[p + 1]);
            total_words += t_area_words[t][a];
            p += 2;
          end
        end
        loaded = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI memory model and FIFO model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (!reset) begin
      rd_left  = 0;
      rd_fetch = 1'b0;
      wr_beat  = 0;
      r        <= '0;
      ar_ready <= 1'b0;
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
    end else begin
      // two beat read bursts are descriptor fetches
      if (ar.valid && ar_ready) begin
        check_value(32'(ar_size), 32'(WORD_SIZE), "read burst size");
        check_value(32'(ar_burst), 32'(INCR_BURST), "read burst type");
        check_value(32'(ar.len == 8'd1 || ar.len == 8'(BURST_BEATS - 1)), 32'd1,
                    "read burst length");
        rq_addr.push_back(ar.addr);
        rq_len.push_back(ar.len);
        if (ar.len == 8'd1) begin
          fetch_q.push_back(ar.addr);
        end
      end
      if (r.valid && r_ready) begin
        // start_write marks data reads only
        check_value(32'(start_write), 32'(!rd_fetch), "start_write during read beat");
        rd_left--;
        rd_addr += 32'd4;
      end
      if (rd_left == 0 && rq_addr.size() > 0) begin
        rd_addr  = rq_addr.pop_front();
        rd_left  = int'(rq_len.pop_front()) + 1;
        rd_fetch = (rd_left == 2);
      end
      b_ar = random_bit();
      b_aw = random_bit();
      b_w  = random_bit();
      b_r  = random_bit();
      ar_ready <= b_ar;
      aw_ready <= b_aw;
      w_ready  <= b_w;
      // a stalled beat holds
      if (!(r.valid && !r_ready)) begin
        if (rd_left > 0 && b_r) begin
          r <= {1'b1, mem_word(rd_addr), rd_left == 1};
        end else begin
          r <= '0;
        end
      end
      // mem to card words
      if (fifo_wr.valid) begin
        card_q.push_back(fifo_wr.data);
        data_words++;
      end
      if (fifo_reset) begin
        reset_count++;
      end
      // write address only once a full burst sits in the FIFO
      if (aw.valid && aw_ready) begin
        check_value(32'(we_count >= written_words + BURST_BEATS), 32'd1,
                    "write burst address before enough FIFO words");
        check_value(32'(aw_size), 32'(WORD_SIZE), "write burst size");
        check_value(32'(aw_burst), 32'(INCR_BURST), "write burst type");
        check_value(32'(aw.len), 32'(BURST_BEATS - 1), "write burst length");
        wr_addr = aw.addr;
        wr_beat = 0;
      end
      if (w.valid && w_ready) begin
        mem[wr_addr] = w.data;
        check_value(32'(w.last), 32'(wr_beat == BURST_BEATS - 1), "w last position");
        check_value(32'(start_write), 32'd0, "start_write during write beat");
        wr_addr += 32'd4;
        wr_beat++;
        written_words++;
        data_words++;
      end
      // serializer done once all words of the test moved
      xfer_compl <= (data_words >= test_words);
    end
  end

  // FIFO head is a counter that restarts with each transfer
  always @(posedge clock) begin
    if (!reset || fifo_reset) begin
      fifo_idx = 0;
    end else if (fifo_rd_pop) begin
      fifo_idx++;
    end
    fifo_rdata <= C2M_BASE + 32'(fifo_idx);
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  // card words arrive as fifo_we pulses once the transfer starts
  task automatic feed_card_words(input int n);
    do @(posedge clock); while (!fifo_reset);
    repeat (n) begin
      @(posedge clock);
      fifo_we <= 1'b1;
      @(posedge clock);
      fifo_we <= 1'b0;
      @(negedge clock);
      we_count++;
    end
  endtask

  task automatic run_test(input int t);
    int base_errors;
    int idx;
    @(negedge clock);
    fetch_q.delete();
    card_q.delete();
    data_words    = 0;
    written_words = 0;
    we_count      = 0;
    reset_count   = 0;
    test_words    = 0;
    for (int a = 0; a < t_na[t]; a++) begin
      test_words += t_area_words[t][a];
    end
    base_errors = errors;
    @(posedge clock);
    cmd <= {1'b1, t_dir[t], 1'b1, 1'b1, t_gap[t], t_ptr[t]};
    @(posedge clock);
    cmd.cmd_done <= 1'b0;
    fork
      begin
        do @(posedge clock); while (dma_interrupts == 2'b00);
      end
      begin
        if (t_dir[t]) begin
          feed_card_words(test_words);
        end
      end
    join
    // window in which a stray fetch would show up
    repeat (20) @(posedge clock);
    check_value(32'(dma_interrupts), 32'(t_irq[t]), "interrupt bits");
    check_value(32'(start_write), 32'd0, "start_write after the chain");
    check_value(32'(reset_count), 32'(t_na[t]), "FIFO reset pulse count");
    check_value(32'(fetch_q.size()), 32'(t_nf[t]), "descriptor fetch count");
    for (int f = 0; f < t_nf[t] && f < fetch_q.size(); f++) begin
      check_value(fetch_q[f], t_fetch[t][f], "descriptor fetch address");
    end
    idx = 0;
    if (!t_dir[t]) begin
      check_value(32'(card_q.size()), 32'(test_words), "FIFO word count");
    end else begin
      check_value(32'(written_words), 32'(test_words), "memory write count");
    end
    for (int a = 0; a < t_na[t]; a++) begin
      for (int k = 0; k < t_area_words[t][a]; k++) begin
        if (t_dir[t]) begin
          check_value(mem_word(t_area_addr[t][a] + 32'(4 * k)), C2M_BASE + 32'(k),
                      "card word in memory");
        end else if (idx < card_q.size()) begin
          check_value(card_q[idx], mem_word(t_area_addr[t][a] + 32'(4 * k)),
                      "memory word into FIFO");
        end
        idx++;
      end
    end
    // clear pulse drops both bits
    @(posedge clock);
    int_clear         <= 1'b1;
    cmd.blk_gap_req   <= 1'b0;
    @(posedge clock);
    int_clear <= 1'b0;
    @(posedge clock);
    @(posedge clock);
    check_value(32'(dma_interrupts), 32'd0, "interrupts after clear");
    $display("test %0d finished, %0d errors", t, errors - base_errors);
  endtask

  // limit scales with the data moved
  initial begin
    wait (loaded === 1'b1);
    repeat (total_words * 40 + 2000) @(posedge clock);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    reset      = 1'b0;
    cmd        = '0;
    xfer_compl = 1'b0;
    int_clear  = 1'b0;
    fifo_we    = 1'b0;
    fifo_rdata = C2M_BASE;
    aw_ready   = 1'b0;
    w_ready    = 1'b0;
    ar_ready   = 1'b0;
    r          = '0;
    lfsr       = 16'd80;
    errors     = 0;
    data_words = 0;
    test_words = 0;
    reset_count = 0;
    load_stim();
    if (!loaded) begin
      $display("stimulus file sd_dma_stim.txt could not be read");
      $display("Done: errors found");
      $finish;
    end else begin
      repeat (10) @(posedge clock);
      reset <= 1'b1;
      repeat (2) @(posedge clock);
      for (int t = 0; t < num_tests; t++) begin
        run_test(t);
      end
      $display("tests run: %0d, errors: %0d", num_tests, errors);
      if (errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

/* sd_dma_stim.txt */
// memory pair count, then address value pairs (descriptor lines)
// tests: ptr dir gap irq nfetch fetch_addr.. narea (addr words)..
00000010
00001000 00200023 00001004 00002000
00001100 00100023 00001104 00003000
00001200 00100021 00001204 00002100
00001208 00000031 0000120c 00005000
00005000 00100023 00005004 00002200
00001300 00000020 00001304 00000000
00001400 00100021 00001404 00002300
00001408 00100023 0000140c 00002400
// number of tests
00000005
// single tran with end, memory to card
00001000 0 0 1 1 00001000 1 00002000 8
// card to memory
00001100 1 0 1 1 00001100 1 00003000 4
// tran, link, tran with end
00001200 0 0 1 3 00001200 00001208 00005000 2 00002100 4 00002200 4
// line with valid clear
00001300 0 0 2 1 00001300 0
// block gap stop after the first line
00001400 0 1 1 1 00001400 1 00002300 4

/* project.f */
dma_pkg.sv
axi_pkg.sv
adma_descriptor_engine.sv
burst_mover.sv
fifo_fill_tracker.sv
sd_dma_top.sv
tb_sd_dma.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the testbench with Verilator, pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sd_dma -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
